// ==== src/gpuPkg.sv ====
package gpuPkg;

  // Host bus.
  localparam int unsigned busAddrWidth = 24;
  localparam int unsigned busDataWidth = 32;

  // One buffer bit per pixel, so a bus word carries 32 pixels.
  localparam int unsigned pixelsPerWord = busDataWidth;
  localparam int unsigned pixelWidth = 9;

  // 800x600 timing.
  localparam int unsigned defaultHorPxl = 800;
  localparam int unsigned defaultVerPxl = 600;
  localparam int unsigned defaultHSync  = 120;
  localparam int unsigned defaultHBack  = 64;
  localparam int unsigned defaultHFront = 56;
  localparam int unsigned defaultVSync  = 6;
  localparam int unsigned defaultVBack  = 23;
  localparam int unsigned defaultVFront = 37;

  localparam bit defaultHSyncPol = 1'b1; // Positive.
  localparam bit defaultVSyncPol = 1'b1; // Positive.

endpackage

// ==== src/videoTiming.sv ====
module videoTiming import gpuPkg::*; #(
  parameter int unsigned horPxl   = defaultHorPxl,
  parameter int unsigned verPxl   = defaultVerPxl,
  parameter int unsigned hSync    = defaultHSync,
  parameter int unsigned hBack    = defaultHBack,
  parameter int unsigned hFront   = defaultHFront,
  parameter int unsigned vSync    = defaultVSync,
  parameter int unsigned vBack    = defaultVBack,
  parameter int unsigned vFront   = defaultVFront,
  parameter bit          hSyncPol = defaultHSyncPol,
  parameter bit          vSyncPol = defaultVSyncPol,
  localparam int unsigned htol    = hSync + hBack + horPxl + hFront,
  localparam int unsigned vtol    = vSync + vBack + verPxl + vFront,
  localparam int unsigned xWidth  = $clog2(htol),
  localparam int unsigned yWidth  = $clog2(vtol)
) (
  input  logic              clk_pixel,
  input  logic              rst_n,
  output logic [xWidth-1:0] x,
  output logic [yWidth-1:0] y,
  output logic              de,
  output logic              hsync,
  output logic              vsync
);

  localparam int unsigned hActStart = hSync + hBack;
  localparam int unsigned vActStart = vSync + vBack;

  logic lineEnd;
  logic frameEnd;

  assign lineEnd  = (x == xWidth'(htol - 1));
  assign frameEnd = (y == yWidth'(vtol - 1));

  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      x <= '0;
      y <= '0;
    end else begin
      if (lineEnd) begin
        x <= '0;
        if (frameEnd) begin
          y <= '0;
        end else begin
          y <= y + 1'b1;
        end
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  // Active while x runs 0 .. hSync-1.
  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      hsync <= hSyncPol;
    end else if (lineEnd) begin
      hsync <= hSyncPol;
    end else if (x == xWidth'(hSync - 1)) begin
      hsync <= ~hSyncPol;
    end
  end

  // Vertical sync only moves at the line boundary.
  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      vsync <= vSyncPol;
    end else if (lineEnd) begin
      if (frameEnd) begin
        vsync <= vSyncPol;
      end else if (y == yWidth'(vSync - 1)) begin
        vsync <= ~vSyncPol;
      end
    end
  end

  assign de = (x >= xWidth'(hActStart)) && (x < xWidth'(hActStart + horPxl)) &&
              (y >= yWidth'(vActStart)) && (y < yWidth'(vActStart + verPxl));

endmodule

// ==== src/frameBuffer.sv ====
module frameBuffer import gpuPkg::*; #(
  parameter int unsigned horPxl    = defaultHorPxl,
  parameter int unsigned verPxl    = defaultVerPxl,
  localparam int unsigned depth    = (horPxl * verPxl) / pixelsPerWord,
  localparam int unsigned addrWidth = $clog2(depth)
) (
  input  logic                    clk_bus,
  input  logic                    clk_pixel,
  input  logic                    rst_n,
  input  logic [busAddrWidth-1:0] busAddress,
  input  logic [busDataWidth-1:0] busWdata,
  input  logic                    busRead,
  input  logic                    busWrite,
  output logic [busDataWidth-1:0] busRdata,
  input  logic [addrWidth-1:0]    pixelAddr,
  output logic [busDataWidth-1:0] pixelWord
);

  logic [busDataWidth-1:0] mem [depth];

  logic [busAddrWidth-3:0] wordSel;
  logic                    inRange;

  assign wordSel = busAddress[busAddrWidth-1:2]; // Byte address to word index.
  assign inRange = (wordSel < depth);

  always_ff @(posedge clk_bus) begin
    if (busWrite && inRange) begin
      mem[wordSel[addrWidth-1:0]] <= busWdata;
    end
  end

  // Read-back sees the old word on a same-cycle write.
  always_ff @(posedge clk_bus or negedge rst_n) begin
    if (!rst_n) begin
      busRdata <= '0;
    end else if (busRead) begin
      busRdata <= inRange ? mem[wordSel[addrWidth-1:0]] : '0;
    end
  end

  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      pixelWord <= '0;
    end else begin
      pixelWord <= mem[pixelAddr];
    end
  end

endmodule

// ==== src/pixelShifter.sv ====
module pixelShifter import gpuPkg::*; #(
  parameter int unsigned horPxl     = defaultHorPxl,
  parameter int unsigned verPxl     = defaultVerPxl,
  localparam int unsigned totalPxl  = horPxl * verPxl,
  localparam int unsigned depth     = totalPxl / pixelsPerWord,
  localparam int unsigned addrWidth = $clog2(depth)
) (
  input  logic                    clk_pixel,
  input  logic                    rst_n,
  input  logic                    de,
  input  logic [busDataWidth-1:0] pixelWord,
  output logic [addrWidth-1:0]    pixelAddr,
  output logic [pixelWidth-1:0]   pxlData
);

  localparam int unsigned cntWidth = $clog2(totalPxl);
  localparam int unsigned bitWidth = $clog2(pixelsPerWord);

  logic [cntWidth-1:0]     pxlCnt;
  logic [bitWidth-1:0]     bitIdx;
  logic [addrWidth-1:0]    wordIdx;
  logic [busDataWidth-1:0] nowWord;
  logic                    nowColor;

  assign bitIdx  = pxlCnt[bitWidth-1:0];
  assign wordIdx = pxlCnt[cntWidth-1:bitWidth];

  // Counts displayed pixels only.
  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      pxlCnt <= '0;
    end else if (de) begin
      if (pxlCnt == cntWidth'(totalPxl - 1)) begin
        pxlCnt <= '0;
      end else begin
        pxlCnt <= pxlCnt + 1'b1;
      end
    end
  end

  // Next word, wrapping to the top of the buffer.
  assign pixelAddr = (wordIdx == addrWidth'(depth - 1)) ? '0 : wordIdx + 1'b1;

  // Swap in the prefetched word as the last bit of the current one goes out.
  always_ff @(posedge clk_pixel or negedge rst_n) begin
    if (!rst_n) begin
      nowWord <= '0;
    end else if (de && bitIdx == bitWidth'(pixelsPerWord - 1)) begin
      nowWord <= pixelWord;
    end
  end

  assign nowColor = nowWord[bitIdx];
  assign pxlData  = (de && nowColor) ? '1 : '0; // Lit pixel is all ones.

endmodule

// ==== src/gpu.sv ====
module gpu import gpuPkg::*; #(
  parameter int unsigned horPxl   = defaultHorPxl,
  parameter int unsigned verPxl   = defaultVerPxl,
  parameter int unsigned hSync    = defaultHSync,
  parameter int unsigned hBack    = defaultHBack,
  parameter int unsigned hFront   = defaultHFront,
  parameter int unsigned vSync    = defaultVSync,
  parameter int unsigned vBack    = defaultVBack,
  parameter int unsigned vFront   = defaultVFront,
  parameter bit          hSyncPol = defaultHSyncPol,
  parameter bit          vSyncPol = defaultVSyncPol
) (
  input  logic                    clk_bus,
  input  logic                    clk_pixel,
  input  logic                    rst_n,
  input  logic [busAddrWidth-1:0] busAddress,
  input  logic [busDataWidth-1:0] busWdata,
  input  logic                    busRead,
  input  logic                    busWrite,
  output logic [busDataWidth-1:0] busRdata,
  output logic                    de,
  output logic                    hsync,
  output logic                    vsync,
  output logic [pixelWidth-1:0]   pxlData
);

  localparam int unsigned xWidth    = $clog2(hSync + hBack + horPxl + hFront);
  localparam int unsigned yWidth    = $clog2(vSync + vBack + verPxl + vFront);
  localparam int unsigned addrWidth = $clog2((horPxl * verPxl) / pixelsPerWord);

  logic [xWidth-1:0]       x;
  logic [yWidth-1:0]       y;
  logic [addrWidth-1:0]    pixelAddr;
  logic [busDataWidth-1:0] pixelWord;

  frameBuffer #(
    .horPxl(horPxl),
    .verPxl(verPxl)
  ) i_frameBuffer (
    .clk_bus   (clk_bus),
    .clk_pixel (clk_pixel),
    .rst_n     (rst_n),
    .busAddress(busAddress),
    .busWdata  (busWdata),
    .busRead   (busRead),
    .busWrite  (busWrite),
    .busRdata  (busRdata),
    .pixelAddr (pixelAddr),
    .pixelWord (pixelWord)
  );

  videoTiming #(
    .horPxl  (horPxl),
    .verPxl  (verPxl),
    .hSync   (hSync),
    .hBack   (hBack),
    .hFront  (hFront),
    .vSync   (vSync),
    .vBack   (vBack),
    .vFront  (vFront),
    .hSyncPol(hSyncPol),
    .vSyncPol(vSyncPol)
  ) i_videoTiming (
    .clk_pixel(clk_pixel),
    .rst_n    (rst_n),
    .x        (x),
    .y        (y),
    .de       (de),
    .hsync    (hsync),
    .vsync    (vsync)
  );

  pixelShifter #(
    .horPxl(horPxl),
    .verPxl(verPxl)
  ) i_pixelShifter (
    .clk_pixel(clk_pixel),
    .rst_n    (rst_n),
    .de       (de),
    .pixelWord(pixelWord),
    .pixelAddr(pixelAddr),
    .pxlData  (pxlData)
  );

endmodule

// ==== tb/clockGen.sv ====
module clockGen #(
  parameter int period = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk; // Free running.
  end

endmodule

// ==== tb/gpu_properties.sv ====
module gpu_properties
  import gpuPkg::*;
#(
  parameter int unsigned hSync    = defaultHSync,
  parameter int unsigned xWidth   = 8,
  parameter bit          hSyncPol = defaultHSyncPol,
  parameter bit          vSyncPol = defaultVSyncPol
) (
  input logic                  clk_pixel,
  input logic                  rst_n,
  input logic [xWidth-1:0]     x,
  input logic                  de,
  input logic                  hsync,
  input logic                  vsync,
  input logic [pixelWidth-1:0] pxlData
);

  int failCount = 0; // Failed assertion attempts.

  deOutsideSync: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    de |-> (hsync != hSyncPol) && (vsync != vSyncPol))
    else begin
      $error("de is high during a sync pulse");
      failCount++;
    end

  pixelBlanked: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    !de |-> (pxlData == '0))
    else begin
      $error("pxlData is not zero outside the active window");
      failCount++;
    end

  // Sync goes active at column 0 and inactive at column hSync.
  hsyncEdges: assert property (@(posedge clk_pixel) disable iff (!rst_n)
    $changed(hsync) |-> (x == '0) || (x == xWidth'(hSync)))
    else begin
      $error("hsync changed away from its line positions");
      failCount++;
    end

endmodule

bind gpu gpu_properties #(
  .hSync   (hSync),
  .xWidth  (xWidth),
  .hSyncPol(hSyncPol),
  .vSyncPol(vSyncPol)
) i_gpuProperties (
  .clk_pixel(clk_pixel),
  .rst_n    (rst_n),
  .x        (x),
  .de       (de),
  .hsync    (hsync),
  .vsync    (vsync),
  .pxlData  (pxlData)
);

// ==== tb/gpuTb.sv ====
module gpuTb
  import gpuPkg::*;
();

  localparam int horPxl = 64;
  localparam int verPxl = 4;
  localparam int hSync  = 4;
  localparam int hBack  = 4;
  localparam int hFront = 4;
  localparam int vSync  = 1;
  localparam int vBack  = 1;
  localparam int vFront = 1;
  localparam int htol = hSync + hBack + horPxl + hFront;
  localparam int vtol = vSync + vBack + verPxl + vFront;
  localparam int pxlTotal = horPxl * verPxl;
  localparam int words = pxlTotal / 32;
  localparam int liveWord = 5; // Rewritten during the second frame.
  localparam int timeoutCycles = 4 * htol * vtol + 200;

  logic                    clk_pixel;
  logic                    clk_bus;
  logic                    rst_n;
  logic [busAddrWidth-1:0] busAddress;
  logic [busDataWidth-1:0] busWdata;
  logic                    busRead;
  logic                    busWrite;
  logic [busDataWidth-1:0] busRdata;
  logic                    de;
  logic                    hsync;
  logic                    vsync;
  logic [pixelWidth-1:0]   pxlData;

  logic [31:0] vec [14];
  logic [31:0] model [words];
  integer      seed = 42;
  int          hPos;
  int          vPos;
  int          pixCount;
  int          n;
  int          expPixel;
  int          cycleCount;
  logic        deExp;

  clockGen #(.period(40)) i_pixelClk (.clk(clk_pixel));
  clockGen #(.period(30)) i_busClk (.clk(clk_bus));

  gpu #(
    .horPxl(horPxl), .verPxl(verPxl), .hSync(hSync), .hBack(hBack), .hFront(hFront),
    .vSync(vSync), .vBack(vBack), .vFront(vFront)
  ) i_gpu (
    .clk_bus(clk_bus), .clk_pixel(clk_pixel), .rst_n(rst_n), .busAddress(busAddress),
    .busWdata(busWdata), .busRead(busRead), .busWrite(busWrite), .busRdata(busRdata),
    .de(de), .hsync(hsync), .vsync(vsync), .pxlData(pxlData)
  );

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  task automatic writeWord(input int idx, input logic [31:0] data);
    @(negedge clk_bus);
    busAddress <= busAddrWidth'(idx * 4);
    busWdata   <= data;
    busWrite   <= 1'b1;
    @(negedge clk_bus);
    busWrite   <= 1'b0;
    model[idx] = data;
  endtask

  task automatic readBack(input logic [31:0] addr);
    logic [31:0] exp;
    exp = model[addr >> 2];
    @(negedge clk_bus);
    busAddress <= addr[busAddrWidth-1:0];
    busRead    <= 1'b1;
    @(negedge clk_bus);
    busRead    <= 1'b0;
    check(busRdata, exp, "bus read-back");
    repeat (3) @(negedge clk_bus);
    check(busRdata, exp, "bus read-back hold");
  endtask

  // Reference raster, one step per pixel clock.
  always @(negedge clk_pixel) begin
    if (!rst_n) begin
      hPos = 0;
      vPos = 0;
      check(hsync, 1, "hsync in reset");
      check(vsync, 1, "vsync in reset");
      check(de, 0, "de in reset");
      check(pxlData, 0, "pxlData in reset");
    end else begin
      if (hPos == htol - 1) begin
        hPos = 0;
        vPos = (vPos == vtol - 1) ? 0 : vPos + 1;
      end else begin
        hPos++;
      end
      deExp = (hPos >= hSync + hBack) && (hPos < hSync + hBack + horPxl) &&
              (vPos >= vSync + vBack) && (vPos < vSync + vBack + verPxl);
      check(hsync, hPos < hSync, "hsync");
      check(vsync, vPos < vSync, "vsync");
      check(de, deExp, "de");
      if (deExp) begin
        if (pixCount >= pxlTotal) begin // Mapping is exact from the second frame.
          n = pixCount % pxlTotal;
          expPixel = model[n / 32][n % 32] ? (1 << pixelWidth) - 1 : 0;
          check(pxlData, expPixel, "pixel value");
        end
        pixCount++;
      end else begin
        check(pxlData, 0, "pxlData outside active window");
      end
    end
  end

  always @(posedge clk_pixel) begin
    cycleCount++;
    if (i_gpu.i_gpuProperties.failCount != 0) begin
      $display("A bound assertion on the video outputs failed");
      $display("TESTBENCH FAILED");
      $fatal(1, "Assertion failure");
    end else if (cycleCount > timeoutCycles) begin
      $display("Run timed out after %0d pixel clock cycles", cycleCount);
      $display("TESTBENCH FAILED");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    rst_n = 1'b0;
    busAddress = '0;
    busWdata = '0;
    busRead = 1'b0;
    busWrite = 1'b0;
    pixCount = 0;
    cycleCount = 0;
    $readmemh("tb/gpuVectors.mem", vec);
    for (int i = 0; i < words; i++) begin
      if (vec[i] == 0) vec[i] = $random(seed);
    end
    repeat (8) @(negedge clk_pixel);
    rst_n <= 1'b1;

    for (int i = 0; i < words; i++) writeWord(i, vec[i]);
    for (int i = 9; i < 14; i++) readBack(vec[i]);

    // Word liveWord of frame two is already out by now.
    while (pixCount < pxlTotal + 200) @(posedge clk_pixel);
    @(negedge clk_bus);
    busAddress <= busAddrWidth'(liveWord * 4);
    busWdata   <= vec[8];
    busWrite   <= 1'b1;
    busRead    <= 1'b1;
    @(negedge clk_bus);
    busWrite   <= 1'b0;
    busRead    <= 1'b0;
    check(busRdata, model[liveWord], "read during write of same word");
    model[liveWord] = vec[8];
    readBack(liveWord * 4);

    while (pixCount < 3 * pxlTotal) @(posedge clk_pixel);
    if (i_gpu.i_gpuProperties.failCount == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("TESTBENCH FAILED");
      $fatal(1, "Assertion failure");
    end
  end

endmodule

// ==== tb/gpuVectors.mem ====
// One 32-bit hex value per line: buffer words 0..7 (zero means random),
// the new value of word 5, then five bus byte addresses to read back.
80000001
F0F0F0F0
0000FFFF
00000000
12345678
CCCC3333
00000000
FFFFFFFE
5AA5C33C
00000000
0000000C
00000016
0000001C
00000004

// ==== sources.f ====
src/gpuPkg.sv
src/videoTiming.sv
src/frameBuffer.sv
src/pixelShifter.sv
src/gpu.sv
tb/clockGen.sv
tb/gpu_properties.sv
tb/gpuTb.sv

// ==== Bender.yml ====
package:
  name: gpu

sources:
  - src/gpuPkg.sv
  - src/videoTiming.sv
  - src/frameBuffer.sv
  - src/pixelShifter.sv
  - src/gpu.sv
  - target: test
    files:
      - tb/clockGen.sv
      - tb/gpu_properties.sv
      - tb/gpuTb.sv
